// ==== logic/branchIsaPkg.sv ====
// branch ISA package: instruction word views, branch classes and decode-stage inputs
package branchIsaPkg;

	// program counter width of the core
	localparam int pcWidth = 48;

	// 16-bit form, only the low halfword is decoded
	typedef struct packed {
		logic [15:0] hiHalf;
		logic [3:0]  opcode;
		logic [3:0]  sub;
		logic [7:0]  disp8;
	} shortView_t;

	// 32-bit form, upper nibble plus low displacement bits in the high halfword
	typedef struct packed {
		logic [3:0]  upper;
		logic [11:0] dispLo;
		logic [3:0]  opcode;
		logic [3:0]  sub;
		logic [7:0]  disp8;
	} longView_t;

	// same word, decoded as either form
	typedef union packed {
		shortView_t shortForm;
		longView_t  longForm;
	} instrWord_u;

	// early branch class of the decode word
	typedef enum logic [2:0] {
		none    = 3'd0,
		bra8    = 3'd1,
		braCc8  = 3'd2,
		bra20   = 3'd3,
		braCc20 = 3'd4,
		rtsu    = 3'd5
	} braClass_e;

	// decode-stage word and its two PCs
	typedef struct packed {
		instrWord_u           word;
		logic [pcWidth-1:0]   basePc;
		logic [pcWidth-1:0]   braPc;
	} decodeIn_t;

	// core mode bits
	typedef struct packed {
		logic riscvMode;
		logic suppress;
	} modeCtl_t;

endpackage

// ==== logic/branchPredPkg.sv ====
// branch predictor package: hysteresis state, resolve and prediction records, state update
package branchPredPkg;

	// 3-bit hysteresis state, taken when bit 2 xor bit 1
	typedef logic [2:0] predState_t;

	// branch outcome from execute
	typedef struct packed {
		logic                               valid;
		logic                               taken;
		logic [branchIsaPkg::pcWidth-1:0]   basePc;
	} resolve_t;

	// fetch redirect toward the front end
	typedef struct packed {
		logic                               redirect;
		logic [branchIsaPkg::pcWidth-1:0]   target;
	} prediction_t;

	// state after one resolved branch
	function automatic predState_t nextState(predState_t state, logic taken);
		predState_t nextVal;
		case (state)
			3'd0: nextVal = taken ? 3'd1 : 3'd6;
			3'd1: nextVal = taken ? 3'd1 : 3'd0;
			3'd2: nextVal = taken ? 3'd0 : 3'd7;
			3'd3: nextVal = taken ? 3'd2 : 3'd7;
			3'd4: nextVal = taken ? 3'd2 : 3'd5;
			3'd5: nextVal = taken ? 3'd4 : 3'd5;
			3'd6: nextVal = taken ? 3'd3 : 3'd4;
			default: nextVal = taken ? 3'd3 : 3'd6;
		endcase
		return nextVal;
	endfunction

endpackage

// ==== logic/braClassify.sv ====
// branch classifier: sorts the decode word into a branch class and sign-extends its displacement
`timescale 1ns/100ps

module braClassify (
	input  branchIsaPkg::instrWord_u word,
	input  branchIsaPkg::modeCtl_t   mode,
	output branchIsaPkg::braClass_e  braClass,
	output logic [31:0]              disp
);

	logic isBra8;
	logic isBraCc8;
	logic isBra20;
	logic isBraCcF20;
	logic isBraCcP20;
	logic isRtsu;
	logic [31:0] disp8Ext;
	logic [31:0] disp20Ext;

	always_comb
	begin
		// short forms, opcode 2 with sub split on bits 11..9
		isBra8   = (word.shortForm.opcode == 4'h2) && (word.shortForm.sub[3:1] == 3'b000);
		isBraCc8 = (word.shortForm.opcode == 4'h2) && (word.shortForm.sub[3:1] == 3'b001);

		// long forms, opcode F keyed on top 3 bits
		isBra20    = (word.longForm.opcode == 4'hF) && (word.longForm.sub == 4'h0) &&
			(word.longForm.upper[3:1] == 3'b110);
		isBraCcF20 = (word.longForm.opcode == 4'hF) && (word.longForm.sub == 4'h0) &&
			(word.longForm.upper[3:1] == 3'b111);
		// predicated form under opcode E
		isBraCcP20 = (word.longForm.opcode == 4'hE) &&
			((word.longForm.sub == 4'h0) || (word.longForm.sub == 4'h4)) &&
			(word.longForm.upper == 4'b1100);

		// return through link register, whole low halfword
		isRtsu = ({word.shortForm.opcode, word.shortForm.sub, word.shortForm.disp8} == 16'h3012);

		// RISC-V mode has no conditional or return forms here
		if (mode.riscvMode)
		begin
			isBraCc8   = 1'b0;
			isBraCcF20 = 1'b0;
			isBraCcP20 = 1'b0;
			isRtsu     = 1'b0;
		end

		// classes are mutually exclusive by opcode and sub
		if (isBra8)
			braClass = branchIsaPkg::bra8;
		else if (isBraCc8)
			braClass = branchIsaPkg::braCc8;
		else if (isBra20)
			braClass = branchIsaPkg::bra20;
		else if (isBraCcF20 || isBraCcP20)
			braClass = branchIsaPkg::braCc20;
		else if (isRtsu)
			braClass = branchIsaPkg::rtsu;
		else
			braClass = branchIsaPkg::none;
	end

	always_comb
	begin
		// low byte sign-extended
		disp8Ext  = {{24{word.shortForm.disp8[7]}}, word.shortForm.disp8};
		// low byte then bits 27..16, sign from bit 7
		disp20Ext = {{12{word.longForm.disp8[7]}}, word.longForm.disp8, word.longForm.dispLo};

		if ((braClass == branchIsaPkg::bra20) || (braClass == branchIsaPkg::braCc20))
			disp = disp20Ext;
		else
			disp = disp8Ext;
	end

endmodule

// ==== logic/braTargetCalc.sv ====
// branch target adder: low 24-bit PC plus doubled displacement, with carry-out detect
`timescale 1ns/100ps

module braTargetCalc (
	input  logic [branchIsaPkg::pcWidth-1:0] braPc,
	input  logic [31:0]                      disp,
	output logic [branchIsaPkg::pcWidth-1:0] target,
	output logic                             wrap
);

	// width of the short adder
	localparam int lowBits = 24;

	logic [lowBits:0] lowSum;
	logic [lowBits:0] dispTwice;

	always_comb
	begin
		// halfword units, so shift left one
		// displacement bit 23 lands in bit 24 as the sign
		dispTwice = {disp[lowBits-1:0], 1'b0};

		// 25-bit add, bit 24 is set when the low part leaves its window
		lowSum = {1'b0, braPc[lowBits-1:0]} + dispTwice;

		// upper PC bits carried through unchanged
		target = {braPc[branchIsaPkg::pcWidth-1:lowBits], lowSum[lowBits-1:0]};

		// target outside the short adder's reach
		wrap = lowSum[lowBits];
	end

endmodule

// ==== logic/patternHistory.sv ====
// gshare pattern history: hysteresis table and global history with fetch read and resolve update
`timescale 1ns/100ps

module patternHistory #(
	parameter int historyBits = 6
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [branchIsaPkg::pcWidth-1:0] fetchPc,
	input  logic [branchIsaPkg::pcWidth-1:0] decodePc,
	input  branchPredPkg::resolve_t          resolve,
	output logic                             predTaken,
	output logic                             indexHit
);

	localparam int entries = 1 << historyBits;

	// state table and global history
	branchPredPkg::predState_t stateTable [entries];
	logic [historyBits-1:0] history;

	// combinational indexes, PC bits above bit 0 hashed with history
	logic [historyBits-1:0] fetchIdx;
	logic [historyBits-1:0] decodeIdx;
	logic [historyBits-1:0] resolveIdx;

	// fetch read stage
	logic [historyBits-1:0]    fetchIdxQ;
	branchPredPkg::predState_t fetchStateQ;

	// resolve read stage
	logic                      resValidQ;
	logic                      resTakenQ;
	logic [historyBits-1:0]    resIdxQ;
	branchPredPkg::predState_t resStateQ;

	always_comb
	begin
		fetchIdx   = fetchPc[historyBits:1] ^ history;
		decodeIdx  = decodePc[historyBits:1] ^ history;
		resolveIdx = resolve.basePc[historyBits:1] ^ history;
	end

	// fetch read, one cycle ahead of decode
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fetchIdxQ   <= '0;
			fetchStateQ <= '0;
		end
		else
		begin
			fetchIdxQ   <= fetchIdx;
			fetchStateQ <= stateTable[fetchIdx];
		end
	end

	// decode must land on the entry fetch looked up
	assign indexHit  = (decodeIdx == fetchIdxQ);
	// taken in states 2..5
	assign predTaken = fetchStateQ[2] ^ fetchStateQ[1];

	// first update stage, capture the outcome and the old entry
	always_ff @(posedge clock)
	begin
		if (reset)
			resValidQ <= 1'b0;
		else
			resValidQ <= resolve.valid;
	end

	always_ff @(posedge clock)
	begin
		if (resolve.valid)
		begin
			resTakenQ <= resolve.taken;
			resIdxQ   <= resolveIdx;
			resStateQ <= stateTable[resolveIdx];
		end
	end

	// second stage, write back and shift history
	// a fetch read on this edge still sees the old entry
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			history <= '0;
			for (int i = 0; i < entries; i++)
			begin
				stateTable[i] <= '0;
			end
		end
		else if (resValidQ)
		begin
			stateTable[resIdxQ] <= branchPredPkg::nextState(resStateQ, resTakenQ);
			history             <= {history[historyBits-2:0], resTakenQ};
		end
	end

endmodule

// ==== logic/earlyBranch.sv ====
// early branch unit: classifies the decode word and decides the fetch redirect and its target
`timescale 1ns/100ps

module earlyBranch #(
	parameter int historyBits = 6
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [branchIsaPkg::pcWidth-1:0] fetchPc,
	input  branchIsaPkg::decodeIn_t          decode,
	input  logic [branchIsaPkg::pcWidth-1:0] linkReg,
	input  branchIsaPkg::modeCtl_t           mode,
	input  branchPredPkg::resolve_t          resolve,
	output branchPredPkg::prediction_t       prediction
);

	branchIsaPkg::braClass_e braClass;
	logic [31:0] disp;
	logic [branchIsaPkg::pcWidth-1:0] calcTarget;
	logic wrap;
	logic predTaken;
	logic indexHit;
	logic isUncond;
	logic isCond;

	braClassify classify0 (
		.word     (decode.word),
		.mode     (mode),
		.braClass (braClass),
		.disp     (disp)
	);

	braTargetCalc target0 (
		.braPc  (decode.braPc),
		.disp   (disp),
		.target (calcTarget),
		.wrap   (wrap)
	);

	patternHistory #(
		.historyBits (historyBits)
	) history0 (
		.clock     (clock),
		.reset     (reset),
		.fetchPc   (fetchPc),
		.decodePc  (decode.basePc),
		.resolve   (resolve),
		.predTaken (predTaken),
		.indexHit  (indexHit)
	);

	always_comb
	begin
		isUncond = (braClass == branchIsaPkg::bra8) || (braClass == branchIsaPkg::bra20);
		isCond   = (braClass == branchIsaPkg::braCc8) || (braClass == branchIsaPkg::braCc20);

		// non-branch falls back to braPc
		if (braClass == branchIsaPkg::rtsu)
			prediction.target = linkReg;
		else if (isUncond || isCond)
			prediction.target = calcTarget;
		else
			prediction.target = decode.braPc;

		// conditional only on a matching index and taken state
		// a carry out of the short adder cancels either form
		prediction.redirect = ((isUncond || (isCond && indexHit && predTaken)) && !wrap) ||
			(braClass == branchIsaPkg::rtsu);

		// pipeline not ready for a redirect
		if (mode.suppress)
			prediction.redirect = 1'b0;
	end

endmodule

// ==== test/clockGen.sv ====
// testbench clock and reset source: 20 ns clock, reset held over the first 3 rising edges
`timescale 1ns/100ps

module clockGen (
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		// release just after the third edge
		repeat (3) @(posedge clock);
		#2;
		reset = 1'b0;
	end

	always #10 clock = ~clock;

endmodule

// ==== test/earlyBranch_assert.sv ====
// early branch assertions: suppress, return redirect and a known redirect after reset
`timescale 1ns/100ps

module earlyBranchAssert (
	input logic                       clock,
	input logic                       reset,
	input branchIsaPkg::decodeIn_t    decode,
	input logic [47:0]                linkReg,
	input branchIsaPkg::modeCtl_t     mode,
	input branchPredPkg::prediction_t prediction
);

	// read back by the testbench at the end of the run
	int failCount = 0;

	// suppress beats every class
	suppressQuiet: assert property (@(posedge clock) disable iff (reset)
		mode.suppress |-> !prediction.redirect)
	else
	begin
		$error("redirect raised while suppress is set");
		failCount++;
	end

	// return word outside RISC-V mode goes to the link register
	returnToLink: assert property (@(posedge clock) disable iff (reset)
		((decode.word[15:0] == 16'h3012) && !mode.riscvMode && !mode.suppress) |->
			(prediction.redirect && (prediction.target == linkReg)))
	else
	begin
		$error("return word did not redirect to the link register");
		failCount++;
	end

	knownRedirect: assert property (@(posedge clock) disable iff (reset)
		!$isunknown(prediction.redirect))
	else
	begin
		$error("redirect is unknown");
		failCount++;
	end

endmodule

bind earlyBranch earlyBranchAssert assert0 (
	.clock      (clock),
	.reset      (reset),
	.decode     (decode),
	.linkReg    (linkReg),
	.mode       (mode),
	.prediction (prediction)
);

// ==== test/earlyBranchTb.sv ====
// early branch testbench: random decode words and resolves checked against a reference model
`timescale 1ns/100ps

module earlyBranchTb;

	localparam int historyBits = 6;
	// worst case, training runs up to 4 resolves of 4 cycles plus fetch and decode
	localparam int maxCycles = 3 + 120 + 40 + 60 + 48 + 60 * 18 + 30 * 6;

	logic clock;
	logic reset;
	logic [47:0] fetchPc;
	logic [47:0] linkReg;
	branchIsaPkg::decodeIn_t decode;
	branchIsaPkg::modeCtl_t mode;
	branchPredPkg::resolve_t resolve;
	branchPredPkg::prediction_t prediction;

	// model of table, history, fetch read stage and resolve stage
	logic [2:0] modelTable [1 << historyBits];
	logic [historyBits-1:0] modelHist;
	logic [historyBits-1:0] fetchIdxModel;
	logic [2:0] fetchStateModel;
	branchPredPkg::resolve_t pendResolve;
	logic [historyBits-1:0] pendIdx;
	logic [2:0] pendState;

	branchPredPkg::prediction_t expected;
	logic checkEnable;
	string testName;
	int testChecks = 0;
	int testErrors = 0;
	int totalChecks = 0;
	int totalErrors = 0;
	int testsRun = 0;
	logic [31:0] rngState;

	clockGen clockGen0 (
		.clock (clock),
		.reset (reset)
	);

	earlyBranch #(
		.historyBits (historyBits)
	) dut0 (
		.clock      (clock),
		.reset      (reset),
		.fetchPc    (fetchPc),
		.decode     (decode),
		.linkReg    (linkReg),
		.mode       (mode),
		.resolve    (resolve),
		.prediction (prediction)
	);

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// halfword aligned
	function automatic logic [47:0] randPc();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = nextRand();
		lo = nextRand();
		return {hi[15:0], lo[31:1], 1'b0};
	endfunction

	// small PC pool so resolves keep landing on the same entries
	function automatic logic [47:0] poolPc(logic [2:0] sel);
		return {44'h0_1234_5678_9A, sel, 1'b0};
	endfunction

	// random word of one class, other fields random
	function automatic logic [31:0] randWord(branchIsaPkg::braClass_e c);
		logic [31:0] r;
		r = nextRand();
		case (c)
			branchIsaPkg::bra8:    return {r[31:16], 4'h2, 3'b000, r[8:0]};
			branchIsaPkg::braCc8:  return {r[31:16], 4'h2, 3'b001, r[8:0]};
			branchIsaPkg::bra20:   return {3'b110, r[28:16], 8'hF0, r[7:0]};
			branchIsaPkg::braCc20:
			begin
				if (r[9])
					return {3'b111, r[28:16], 8'hF0, r[7:0]};
				return {4'hC, r[27:16], 4'hE, 1'b0, r[10], 2'b00, r[7:0]};
			end
			branchIsaPkg::rtsu:    return {r[31:16], 16'h3012};
			default:               return {r[31:16], 4'h5, r[11:0]};
		endcase
	endfunction

	function automatic branchIsaPkg::decodeIn_t mkDecode(logic [31:0] w, logic [47:0] base,
		logic [47:0] bra);
		branchIsaPkg::decodeIn_t d;
		d.word = w;
		d.basePc = base;
		d.braPc = bra;
		return d;
	endfunction

	function automatic branchIsaPkg::decodeIn_t idleDecode();
		return mkDecode(randWord(branchIsaPkg::none), randPc(), randPc());
	endfunction

	// hysteresis transitions, taken and not taken
	function automatic logic [2:0] refNextState(logic [2:0] s, logic taken);
		logic [2:0] onTaken [8];
		logic [2:0] onNot [8];
		onTaken = '{3'd1, 3'd1, 3'd0, 3'd2, 3'd2, 3'd4, 3'd3, 3'd3};
		onNot = '{3'd6, 3'd0, 3'd7, 3'd7, 3'd5, 3'd5, 3'd4, 3'd6};
		return taken ? onTaken[s] : onNot[s];
	endfunction

	// expected class, target, wrap and redirect of one decode cycle
	function automatic branchPredPkg::prediction_t refPredict(branchIsaPkg::decodeIn_t d,
		logic [47:0] lr, branchIsaPkg::modeCtl_t m, logic hit, logic [2:0] st);
		branchPredPkg::prediction_t p;
		logic [31:0] w;
		logic uncond;
		logic cond;
		logic ret;
		logic long20;
		logic wrap;
		longint sum;
		w = d.word;
		long20 = ((w[15:8] == 8'hF0) && (w[31:30] == 2'b11)) ||
			(((w[15:8] == 8'hE0) || (w[15:8] == 8'hE4)) && (w[31:28] == 4'hC));
		uncond = ((w[15:12] == 4'h2) && (w[11:9] == 3'd0)) ||
			((w[15:8] == 8'hF0) && (w[31:29] == 3'b110));
		cond = !m.riscvMode && (((w[15:12] == 4'h2) && (w[11:9] == 3'd1)) || (long20 && !uncond));
		ret = !m.riscvMode && (w[15:0] == 16'h3012);
		// signed halfword count, sign taken from bit 7 in both forms
		if (long20)
			sum = longint'($signed({w[7:0], w[27:16]}));
		else
			sum = longint'($signed(w[7:0]));
		sum = 2 * sum + longint'(d.braPc[23:0]);
		wrap = (sum < 0) || (sum > 16777215);
		p.target = d.braPc;
		if (ret)
			p.target = lr;
		else if (uncond || cond)
			p.target = {d.braPc[47:24], sum[23:0]};
		p.redirect = ret || (!wrap && (uncond || (cond && hit && (st[2] ^ st[1]))));
		if (m.suppress)
			p.redirect = 1'b0;
		return p;
	endfunction

	// drive one cycle, set its expectation, then step the model over the edge
	task automatic driveCycle(branchIsaPkg::decodeIn_t d, logic [47:0] fpc,
		branchIsaPkg::modeCtl_t m, branchPredPkg::resolve_t r);
		logic [historyBits-1:0] decodeIdx;
		logic [historyBits-1:0] nextFetchIdx;
		logic [historyBits-1:0] capIdx;
		logic [2:0] nextFetchState;
		logic [2:0] capState;
		decode = d;
		fetchPc = fpc;
		mode = m;
		resolve = r;
		linkReg = randPc();
		decodeIdx = d.basePc[historyBits:1] ^ modelHist;
		expected = refPredict(d, linkReg, m, decodeIdx == fetchIdxModel, fetchStateModel);
		checkEnable = 1'b1;
		@(posedge clock);
		// both reads see the table before this edge's write
		nextFetchIdx = fpc[historyBits:1] ^ modelHist;
		nextFetchState = modelTable[nextFetchIdx];
		capIdx = r.basePc[historyBits:1] ^ modelHist;
		capState = modelTable[capIdx];
		if (pendResolve.valid)
		begin
			modelTable[pendIdx] = refNextState(pendState, pendResolve.taken);
			modelHist = {modelHist[historyBits-2:0], pendResolve.taken};
		end
		pendResolve = r;
		pendIdx = capIdx;
		pendState = capState;
		fetchIdxModel = nextFetchIdx;
		fetchStateModel = nextFetchState;
		#2;
	endtask

	// one resolve then the 3 quiet cycles before any prediction
	task automatic resolveAndWait(logic [47:0] pc);
		logic [31:0] r;
		r = nextRand();
		driveCycle(idleDecode(), randPc(), 2'b00, {1'b1, r[0], pc});
		repeat (3) driveCycle(idleDecode(), randPc(), 2'b00, '0);
	endtask

	task automatic finishTest();
		$display("test %s: %0d checks, %0d errors", testName, testChecks, testErrors);
		totalChecks += testChecks;
		totalErrors += testErrors;
		testsRun++;
		testChecks = 0;
		testErrors = 0;
	endtask

	// mid-cycle compare, inputs settled since the drive point
	always @(negedge clock)
	begin
		if (checkEnable)
		begin
			testChecks++;
			if (prediction.redirect !== expected.redirect)
			begin
				$display("error %s: redirect expected %0b actual %0b", testName,
					expected.redirect, prediction.redirect);
				testErrors++;
			end
			if (prediction.target !== expected.target)
			begin
				$display("error %s: target expected %h actual %h", testName,
					expected.target, prediction.target);
				testErrors++;
			end
		end
	end

	initial
	begin
		#(maxCycles * 20 + 2000);
		$display("watchdog expired, the tests did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		logic [31:0] r;
		logic [47:0] pc;
		logic [31:0] w;
		fetchPc = '0;
		decode = '0;
		linkReg = '0;
		mode = '0;
		resolve = '0;
		checkEnable = 1'b0;
		rngState = 32'heda7;
		modelHist = '0;
		fetchIdxModel = '0;
		fetchStateModel = '0;
		pendResolve = '0;
		for (int i = 0; i < (1 << historyBits); i++)
			modelTable[i] = '0;
		wait (!reset);

		testName = "unconditional";
		for (int i = 0; i < 120; i++)
		begin
			r = nextRand();
			w = randWord(r[0] ? branchIsaPkg::bra8 : branchIsaPkg::bra20);
			driveCycle(mkDecode(w, randPc(), randPc()), randPc(), 2'b00, '0);
		end
		finishTest();

		// forward from the top of the window, backward from its bottom
		testName = "wrap cancel";
		for (int i = 0; i < 40; i++)
		begin
			r = nextRand();
			w = randWord(i[1] ? branchIsaPkg::bra20 : branchIsaPkg::bra8);
			pc = randPc();
			w[7:0] = i[0] ? 8'h80 : 8'h7F;
			pc[23:0] = i[0] ? {20'h00000, r[3:1], 1'b0} : {20'hFFFFF, r[3:1], 1'b0};
			driveCycle(mkDecode(w, randPc(), pc), randPc(), 2'b00, '0);
		end
		finishTest();

		// every class, first in normal then in RISC-V mode
		testName = "return and mode";
		for (int i = 0; i < 60; i++)
		begin
			w = randWord(branchIsaPkg::braClass_e'(i % 6));
			driveCycle(mkDecode(w, randPc(), randPc()), randPc(), {i % 12 >= 6, 1'b0}, '0);
		end
		finishTest();

		testName = "suppress";
		for (int i = 0; i < 48; i++)
		begin
			r = nextRand();
			w = randWord(branchIsaPkg::braClass_e'(i % 6));
			driveCycle(mkDecode(w, randPc(), randPc()), randPc(), {r[0], 1'b1}, '0);
		end
		finishTest();

		testName = "conditional training";
		for (int i = 0; i < 60; i++)
		begin
			r = nextRand();
			for (int b = 0; b <= r[1:0]; b++)
				resolveAndWait(poolPc(r[3 * b + 4 +: 3]));
			pc = poolPc(r[18:16]);
			// fetch reads the entry, decode of the same PC follows
			driveCycle(idleDecode(), pc, 2'b00, '0);
			w = randWord(r[20] ? branchIsaPkg::braCc8 : branchIsaPkg::braCc20);
			driveCycle(mkDecode(w, pc, randPc()), randPc(), 2'b00, '0);
		end
		finishTest();

		testName = "index mismatch";
		for (int i = 0; i < 30; i++)
		begin
			r = nextRand();
			pc = poolPc(r[2:0]);
			resolveAndWait(pc);
			driveCycle(idleDecode(), pc, 2'b00, '0);
			// at least one index bit differs from the fetch PC
			pc[6:1] = pc[6:1] ^ (r[13:8] | 6'd1);
			w = randWord(r[20] ? branchIsaPkg::braCc8 : branchIsaPkg::braCc20);
			driveCycle(mkDecode(w, pc, randPc()), randPc(), 2'b00, '0);
		end
		finishTest();

		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d", testsRun,
			totalChecks, totalErrors, dut0.assert0.failCount);
		if ((totalErrors == 0) && (dut0.assert0.failCount == 0))
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== earlyBranch.f ====
logic/branchIsaPkg.sv
logic/branchPredPkg.sv
logic/braClassify.sv
logic/braTargetCalc.sv
logic/patternHistory.sv
logic/earlyBranch.sv
test/clockGen.sv
test/earlyBranch_assert.sv
test/earlyBranchTb.sv

// ==== Bender.yml ====
package:
  name: earlyBranch

sources:
  # packages first, then the RTL blocks and the top level
  - logic/branchIsaPkg.sv
  - logic/branchPredPkg.sv
  - logic/braClassify.sv
  - logic/braTargetCalc.sv
  - logic/patternHistory.sv
  - logic/earlyBranch.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/earlyBranch_assert.sv
      - test/earlyBranchTb.sv
